// File: common/convAccel_defs.svh
`ifndef CONV_ACCEL_DEFS_SVH
`define CONV_ACCEL_DEFS_SVH

// image frame size in pixels
`define IMG_W 8
`define IMG_H 8

// 3x3 kernel, coefficients arrive in raster order
`define KERNEL_TAPS 9

// command codes on ctrl
`define CMD_LOAD_WEIGHTS 4'd1
`define CMD_COMPUTE 4'd2

`endif

// File: common/convPkg.sv
`include "convAccel_defs.svh"

package convPkg;

  typedef logic [7:0] pixel_t;         // unsigned sample or raw stream byte

  typedef logic signed [7:0] weight_t; // signed kernel coefficient

  // tap 0 is the top-left coefficient, tap 8 the bottom-right
  typedef weight_t [`KERNEL_TAPS-1:0] kernel_t;

  typedef logic signed [19:0] convSum_t; // holds nine 255 * -128 products

  typedef logic [3:0] cmd_t;

  typedef enum logic [1:0] {
    idle        = 2'd0,
    loadWeights = 2'd1,
    compute     = 2'd2,
    flush       = 2'd3
  } seqState_t;

endpackage

// File: common/pixStreamIf.sv
`timescale 1ns/1ps

interface pixStreamIf;

  convPkg::pixel_t data;
  logic            valid;
  logic            ready;
  logic            last;

  modport source (
    output data,
    output valid,
    output last,
    input  ready
  );

  modport sink (
    input  data,
    input  valid,
    input  last,
    output ready
  );

endinterface

// File: rtl/streamRouter.sv
`timescale 1ns/1ps
`include "convAccel_defs.svh"

module streamRouter (
  input  logic            clk,
  input  logic            rst,
  input  convPkg::cmd_t   ctrl,
  pixStreamIf.sink        src,
  pixStreamIf.source      weightStream,
  pixStreamIf.source      imageStream
);

  logic destImage; // 0 selects the weight sink, 1 the image sink

  // destination follows every load or compute code, whatever the job state
  always_ff @(posedge clk) begin
    if (rst) begin
      destImage <= 1'b0;
    end else if (ctrl == `CMD_LOAD_WEIGHTS) begin
      destImage <= 1'b0;
    end else if (ctrl == `CMD_COMPUTE) begin
      destImage <= 1'b1;
    end
  end

  assign weightStream.valid = src.valid & ~destImage;
  assign weightStream.data  = destImage ? '0 : src.data;
  assign weightStream.last  = src.last & ~destImage;

  assign imageStream.valid  = src.valid & destImage;
  assign imageStream.data   = destImage ? src.data : '0;
  assign imageStream.last   = src.last & destImage;

  assign src.ready = destImage ? imageStream.ready : weightStream.ready; // ready of selected sink

  // a beat must never be offered to both consumers at once
  oneSinkValid: assert property (
    @(posedge clk) disable iff (rst)
    !(weightStream.valid && imageStream.valid)
  );

endmodule

// File: rtl/convSequencer.sv
`timescale 1ns/1ps
`include "convAccel_defs.svh"

module convSequencer (
  input  logic                clk,
  input  logic                rst,
  input  convPkg::cmd_t       ctrl,
  input  logic                kernelDone,
  input  logic                frameDone,
  output logic                startLoad,
  output logic                startCompute,
  output logic                dmaReadValid,
  output logic                dmaWriteValid,
  output convPkg::seqState_t  state
);

  convPkg::seqState_t nextState;

  always_comb begin
    nextState = state;
    case (state)
      convPkg::idle: begin
        if (ctrl == `CMD_LOAD_WEIGHTS) begin
          nextState = convPkg::loadWeights;
        end else if (ctrl == `CMD_COMPUTE) begin
          nextState = convPkg::compute;
        end
      end
      convPkg::loadWeights: begin
        if (kernelDone) nextState = convPkg::idle;
      end
      convPkg::compute: begin
        if (frameDone) nextState = convPkg::flush;
      end
      default: nextState = convPkg::idle; // flush lasts one cycle
    endcase
  end

  // strobes are registered so they land in the first cycle of the new state
  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= convPkg::idle;
      startLoad     <= 1'b0;
      startCompute  <= 1'b0;
      dmaReadValid  <= 1'b0;
      dmaWriteValid <= 1'b0;
    end else begin
      state         <= nextState;
      startLoad     <= (state == convPkg::idle) && (nextState == convPkg::loadWeights);
      startCompute  <= (state == convPkg::idle) && (nextState == convPkg::compute);
      dmaReadValid  <= (state == convPkg::idle) && (nextState != convPkg::idle);
      dmaWriteValid <= (nextState == convPkg::flush); // high for the single flush cycle
    end
  end

  // a job is either a kernel load or a frame, never both
  startExclusive: assert property (
    @(posedge clk) disable iff (rst)
    !(startLoad && startCompute)
  );

endmodule

// File: rtl/weightBuffer.sv
`timescale 1ns/1ps
`include "convAccel_defs.svh"

module weightBuffer (
  input  logic              clk,
  input  logic              rst,
  input  logic              startLoad,
  pixStreamIf.sink          in,
  output convPkg::kernel_t  kernel,
  output logic              kernelDone
);

  localparam int TapW = $clog2(`KERNEL_TAPS + 1);

  logic [TapW-1:0] tapCount; // taps filled so far
  logic [TapW-1:0] tapIdx;   // tap written by the current beat
  logic            accept;

  // startLoad restarts at tap 0 even if a byte lands in the same cycle
  assign tapIdx = startLoad ? '0 : tapCount;

  assign in.ready = (tapCount < TapW'(`KERNEL_TAPS));
  assign accept   = in.valid & in.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      tapCount   <= '0;
      kernel     <= '0;
      kernelDone <= 1'b0;
    end else begin
      kernelDone <= accept && (tapIdx == TapW'(`KERNEL_TAPS - 1));
      if (accept) begin
        kernel[tapIdx] <= in.data; // raw byte reinterpreted as signed weight
        tapCount       <= tapIdx + 1'b1;
      end else if (startLoad) begin
        tapCount <= '0;
      end
    end
  end

  // once full, the kernel stays untouched until the next load job
  noOverfill: assert property (
    @(posedge clk) disable iff (rst)
    (tapCount == TapW'(`KERNEL_TAPS)) && !startLoad |-> !accept
  );

endmodule

// File: conv3x3/conv3x3Engine.sv
`timescale 1ns/1ps
`include "convAccel_defs.svh"

module conv3x3Engine (
  input  logic               clk,
  input  logic               rst,
  input  logic               startCompute,
  pixStreamIf.sink           in,
  input  convPkg::kernel_t   kernel,
  output convPkg::convSum_t  mData,
  output logic               mValid,
  input  logic               mReady,
  output logic               mLast,
  output logic               frameDone
);

  localparam int ColW = $clog2(`IMG_W);
  localparam int RowW = $clog2(`IMG_H);

  logic [ColW-1:0] col;
  logic [RowW-1:0] row;
  logic [ColW-1:0] colEff; // position of the pixel on the input this cycle
  logic [RowW-1:0] rowEff;

  convPkg::pixel_t lineBuf0 [`IMG_W]; // previous row
  convPkg::pixel_t lineBuf1 [`IMG_W]; // row before that

  convPkg::pixel_t win    [3][3]; // [row][col], col 2 is the newest
  convPkg::pixel_t nxtWin [3][3];

  convPkg::convSum_t acc;
  convPkg::convSum_t winSum;

  logic accept;
  logic windowReady;
  logic lastPix;

  assign colEff = startCompute ? '0 : col;
  assign rowEff = startCompute ? '0 : row;

  // input stalls only while a result is waiting and not being taken
  assign in.ready = ~mValid | mReady;
  assign accept   = in.valid & in.ready;

  assign windowReady = (rowEff >= RowW'(2)) && (colEff >= ColW'(2));
  assign lastPix     = (rowEff == RowW'(`IMG_H - 1)) && (colEff == ColW'(`IMG_W - 1));

  // window as it will be after this pixel shifts in
  always_comb begin
    for (int r = 0; r < 3; r++) begin
      nxtWin[r][0] = win[r][1];
      nxtWin[r][1] = win[r][2];
    end
    nxtWin[0][2] = lineBuf1[colEff];
    nxtWin[1][2] = lineBuf0[colEff];
    nxtWin[2][2] = in.data;
  end

  // tap r*3+k weights window pixel (r,k), pixels zero-extended to signed
  always_comb begin
    acc = '0;
    for (int r = 0; r < 3; r++) begin
      for (int k = 0; k < 3; k++) begin
        acc = acc + $signed({1'b0, nxtWin[r][k]}) * convPkg::weight_t'(kernel[r*3+k]);
      end
    end
    winSum = acc;
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      lineBuf1[colEff] <= lineBuf0[colEff];
      lineBuf0[colEff] <= in.data;
      win              <= nxtWin;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      col <= '0;
      row <= '0;
    end else if (accept) begin
      if (colEff == ColW'(`IMG_W - 1)) begin
        col <= '0;
        row <= lastPix ? '0 : rowEff + 1'b1; // wrap so the next frame starts clean
      end else begin
        col <= colEff + 1'b1;
        row <= rowEff;
      end
    end else if (startCompute) begin
      col <= '0;
      row <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept && windowReady) begin
      mData <= winSum;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mValid    <= 1'b0;
      mLast     <= 1'b0;
      frameDone <= 1'b0;
    end else begin
      frameDone <= mValid & mReady & mLast;
      if (accept && windowReady) begin
        mValid <= 1'b1;
        mLast  <= lastPix;
      end else if (mReady) begin
        mValid <= 1'b0;
        mLast  <= 1'b0;
      end
    end
  end

  // a stalled result must not change under the consumer
  holdWhileStalled: assert property (
    @(posedge clk) disable iff (rst)
    mValid && !mReady |=> $stable(mData) && $stable(mLast)
  );

endmodule

// File: rtl/convAccelTop.sv
`timescale 1ns/1ps

module convAccelTop (
  input  logic                clk,
  input  logic                rst,
  input  convPkg::cmd_t       ctrl,
  input  convPkg::pixel_t     sData,
  input  logic                sValid,
  output logic                sReady,
  output convPkg::convSum_t   mData,
  output logic                mValid,
  input  logic                mReady,
  output logic                mLast,
  output logic                dmaReadValid,
  output logic                dmaWriteValid,
  output convPkg::seqState_t  state
);

  pixStreamIf srcStream ();
  pixStreamIf weightStream ();
  pixStreamIf imageStream ();

  convPkg::kernel_t kernel;
  logic startLoad;
  logic startCompute;
  logic kernelDone;
  logic frameDone;

  assign srcStream.data  = sData;
  assign srcStream.valid = sValid;
  assign srcStream.last  = 1'b0; // frame ends come from the engine counters
  assign sReady          = srcStream.ready;

  streamRouter router_i (
    .clk          (clk),
    .rst          (rst),
    .ctrl         (ctrl),
    .src          (srcStream),
    .weightStream (weightStream),
    .imageStream  (imageStream)
  );

  convSequencer sequencer_i (
    .clk           (clk),
    .rst           (rst),
    .ctrl          (ctrl),
    .kernelDone    (kernelDone),
    .frameDone     (frameDone),
    .startLoad     (startLoad),
    .startCompute  (startCompute),
    .dmaReadValid  (dmaReadValid),
    .dmaWriteValid (dmaWriteValid),
    .state         (state)
  );

  weightBuffer weights_i (
    .clk        (clk),
    .rst        (rst),
    .startLoad  (startLoad),
    .in         (weightStream),
    .kernel     (kernel),
    .kernelDone (kernelDone)
  );

  conv3x3Engine engine_i (
    .clk          (clk),
    .rst          (rst),
    .startCompute (startCompute),
    .in           (imageStream),
    .kernel       (kernel),
    .mData        (mData),
    .mValid       (mValid),
    .mReady       (mReady),
    .mLast        (mLast),
    .frameDone    (frameDone)
  );

endmodule

// File: sim/convAccelTb.sv
`timescale 1ns/1ps
`include "convAccel_defs.svh"

module convAccelTb;

  localparam int Pixels        = `IMG_W * `IMG_H;
  localparam int Results       = (`IMG_W - 2) * (`IMG_H - 2);
  localparam int TimeoutCycles = 2 * (Pixels + Results) * 4 + 300; // two frames plus setup

  logic               clk;
  logic               rst;
  convPkg::cmd_t      ctrl;
  convPkg::pixel_t    sData;
  logic               sValid;
  logic               sReady;
  convPkg::convSum_t  mData;
  logic               mValid;
  logic               mReady;
  logic               mLast;
  logic               dmaReadValid;
  logic               dmaWriteValid;
  convPkg::seqState_t state;

  logic [31:0]       seed;
  logic signed [7:0] wgt [`KERNEL_TAPS];
  convPkg::pixel_t   img [2][Pixels];
  logic              readyPat [TimeoutCycles]; // one mReady value per cycle
  convPkg::convSum_t expQ [$];                 // expected sums in raster order
  string             curTest = "reset";
  int errCount = 0;
  int testsRun = 0;
  int testsFailed = 0;
  int resultCount = 0;
  int readPulses = 0;
  int writePulses = 0;
  int inAccepts = 0;
  int stallCycles = 0;
  int cycleCount = 0;

  convAccelTop dut_i (
    .clk(clk), .rst(rst), .ctrl(ctrl), .sData(sData), .sValid(sValid), .sReady(sReady),
    .mData(mData), .mValid(mValid), .mReady(mReady), .mLast(mLast),
    .dmaReadValid(dmaReadValid), .dmaWriteValid(dmaWriteValid), .state(state)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic reportMismatch(input string what, input int expVal, input int actVal);
    $display("MISMATCH test %s %s expected %0d actual %0d", curTest, what, expVal, actVal);
    errCount++;
  endtask

  task automatic reportFailure(input string msg);
    $display("ERROR test %s: %s", curTest, msg);
    errCount++;
  endtask

  task automatic finishTest(input int startErr);
    testsRun++;
    if (errCount == startErr) begin
      $display("test %s ok", curTest);
    end else begin
      testsFailed++;
      $display("test %s failed with %0d errors", curTest, errCount - startErr);
    end
  endtask

  task automatic genStimulus();
    seed = 32'habd1;
    for (int t = 0; t < `KERNEL_TAPS; t++) begin
      seed   = lcgNext(seed);
      wgt[t] = seed[23:16];
    end
    for (int f = 0; f < 2; f++) begin
      for (int p = 0; p < Pixels; p++) begin
        seed      = lcgNext(seed);
        img[f][p] = seed[23:16];
      end
    end
    for (int k = 0; k < TimeoutCycles; k++) begin
      seed        = lcgNext(seed);
      readyPat[k] = (seed[23:16] % 100) < 70; // about 70% ready
    end
  endtask

  // valid-region sums, tap i*3+j weights window row i, column j
  task automatic buildExpected(input int f);
    int s;
    expQ.delete();
    for (int r = 2; r < `IMG_H; r++) begin
      for (int c = 2; c < `IMG_W; c++) begin
        s = 0;
        for (int i = 0; i < 3; i++) begin
          for (int j = 0; j < 3; j++) begin
            s += int'(img[f][(r - 2 + i) * `IMG_W + (c - 2 + j)]) * int'(wgt[i * 3 + j]);
          end
        end
        expQ.push_back(convPkg::convSum_t'(s));
      end
    end
  endtask

  // called 2 ns after an edge, returns 2 ns after the accepting edge
  task automatic sendByte(input convPkg::pixel_t b);
    sData  = b;
    sValid = 1'b1;
    @(posedge clk);
    while (!sReady) @(posedge clk);
    #2;
  endtask

  task automatic checkReset();
    int startErr;
    startErr = errCount;
    @(posedge clk);
    assert (state == convPkg::idle) else reportFailure("state is not idle after reset");
    assert (!mValid && !mLast) else reportFailure("output stream is active after reset");
    assert (!dmaReadValid && !dmaWriteValid) else reportFailure("DMA strobe high after reset");
    finishTest(startErr);
  endtask

  task automatic loadKernel();
    int startErr;
    int readBase;
    int acceptBase;
    curTest    = "loadWeights";
    startErr   = errCount;
    readBase   = readPulses;
    acceptBase = inAccepts;
    #2 ctrl = `CMD_LOAD_WEIGHTS;
    @(posedge clk);
    #2 ctrl = '0;
    for (int t = 0; t < `KERNEL_TAPS; t++) begin
      sendByte(convPkg::pixel_t'(wgt[t]));
    end
    sData = 8'h7f; // offered beyond the ninth tap, must be refused
    repeat (4) @(posedge clk);
    #2 sValid = 1'b0;
    @(posedge clk);
    #2;
    assert (inAccepts - acceptBase == `KERNEL_TAPS)
      else reportMismatch("accepted bytes", `KERNEL_TAPS, inAccepts - acceptBase);
    assert (readPulses - readBase == 1)
      else reportMismatch("dmaReadValid pulses", 1, readPulses - readBase);
    assert (state == convPkg::idle) else reportFailure("state did not return to idle");
    finishTest(startErr);
  endtask

  task automatic runFrame(input int f, input string name);
    int startErr;
    int readBase;
    int writeBase;
    curTest   = name;
    startErr  = errCount;
    readBase  = readPulses;
    writeBase = writePulses;
    buildExpected(f);
    resultCount = 0;
    ctrl = `CMD_COMPUTE;
    @(posedge clk);
    #2 ctrl = '0;
    for (int p = 0; p < Pixels; p++) begin
      sendByte(img[f][p]);
    end
    sValid = 1'b0;
    while (state != convPkg::flush) @(posedge clk);
    while (state != convPkg::idle) @(posedge clk);
    #2;
    assert (resultCount == Results) else reportMismatch("result count", Results, resultCount);
    assert (expQ.size() == 0) else reportFailure("expected results were never delivered");
    assert (readPulses - readBase == 1)
      else reportMismatch("dmaReadValid pulses", 1, readPulses - readBase);
    assert (writePulses - writeBase == 1)
      else reportMismatch("dmaWriteValid pulses", 1, writePulses - writeBase);
    finishTest(startErr);
  endtask

  // compare every accepted result with the model
  always @(posedge clk) begin : handshakeCheck
    convPkg::convSum_t expVal;
    if (!rst && mValid && mReady) begin
      if (expQ.size() == 0) begin
        reportFailure("result arrived with no expected value left");
      end else begin
        expVal = expQ.pop_front();
        assert (mData == expVal) else reportMismatch("mData", expVal, mData);
      end
      assert (mLast == (resultCount == Results - 1))
        else reportMismatch("mLast", resultCount == Results - 1, mLast);
      resultCount++;
    end
  end

  always @(posedge clk) begin
    if (!rst) begin
      if (dmaReadValid) readPulses++;
      if (dmaWriteValid) writePulses++;
      if (sValid && sReady) inAccepts++;
      if (mValid && !mReady) stallCycles++;
    end
  end

  stallHold: assert property (@(posedge clk) disable iff (rst)
    mValid && !mReady |=> mValid && $stable(mData) && $stable(mLast))
    else reportFailure("result changed or dropped while the output was stalled");

  readOnCommand: assert property (@(posedge clk) disable iff (rst)
    (state == convPkg::idle) && (ctrl == `CMD_LOAD_WEIGHTS || ctrl == `CMD_COMPUTE)
    |=> dmaReadValid)
    else reportFailure("no dmaReadValid pulse after a command in idle");

  // write strobe two edges after the last result is taken, and never otherwise
  writeAfterLast: assert property (@(posedge clk) disable iff (rst)
    dmaWriteValid == $past(mValid && mReady && mLast, 2))
    else reportFailure("dmaWriteValid does not follow the last result");

  initial begin
    mReady = 1'b0;
    forever begin
      @(posedge clk);
      #2 mReady = readyPat[cycleCount % TimeoutCycles];
    end
  end

  initial begin
    while (cycleCount < TimeoutCycles) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("ERROR: run did not finish within %0d cycles", TimeoutCycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    rst    = 1'b1;
    ctrl   = '0;
    sData  = '0;
    sValid = 1'b0;
    genStimulus();
    repeat (16) @(posedge clk);
    #2 rst = 1'b0;
    checkReset();
    loadKernel();
    runFrame(0, "frame1");
    runFrame(1, "frame2Reuse"); // same kernel, no reload
    $display("tests %0d, failed %0d, errors %0d, stall cycles %0d",
             testsRun, testsFailed, errCount, stallCycles);
    if (errCount == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+common
common/convPkg.sv
common/pixStreamIf.sv
rtl/streamRouter.sv
rtl/convSequencer.sv
rtl/weightBuffer.sv
conv3x3/conv3x3Engine.sv
rtl/convAccelTop.sv
sim/convAccelTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module convAccelTb -o simv

out=$(./obj_dir/simv)
echo "$out"

if grep -qF "*** TEST PASSED ***" <<< "$out"; then
  exit 0
else
  exit 1
fi
